/* apb_gpio.sv */
/*
 * apb gpio block
 * dir/out/irqen registers, input sync, rising-edge event pulses
 */
`timescale 1ns/1ps
`include "soc_periph_defines.svh"

module apb_gpio (
  input  logic                     clk_i,
  input  logic                     arst_n_i,
  input  soc_periph_pkg::apb_req_t req_i,
  output soc_periph_pkg::apb_rsp_t rsp_o,
  input  logic [`N_GPIO-1:0]       gpio_in_i,
  output logic [`N_GPIO-1:0]       gpio_out_o,
  output logic [`N_GPIO-1:0]       gpio_dir_o,
  output logic [`N_GPIO-1:0]       gpio_evt_o
);
  import soc_periph_pkg::*;

  apb_op_e            op;
  logic [7:0]         offs;
  logic [`N_GPIO-1:0] dir_q;    // 1 = output
  logic [`N_GPIO-1:0] out_q;
  logic [`N_GPIO-1:0] irqen_q;
  logic [`N_GPIO-1:0] sync1_q;
  logic [`N_GPIO-1:0] sync2_q;
  logic [`N_GPIO-1:0] prev_q;   // last synced value
  logic [`N_GPIO-1:0] evt_q;

  assign op   = apb_op(req_i);
  assign offs = req_i.paddr[7:0];

  ////////////////////
  // registers
  ////////////////////
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      dir_q   <= '0;
      out_q   <= '0;
      irqen_q <= '0;
    end else if (op == OP_WRITE) begin
      case (offs)
        `GPIO_DIR:   dir_q   <= req_i.pwdata[`N_GPIO-1:0];
        `GPIO_OUT:   out_q   <= req_i.pwdata[`N_GPIO-1:0];
        `GPIO_IRQEN: irqen_q <= req_i.pwdata[`N_GPIO-1:0];
        default: ;  // IN is read only
      endcase
    end
  end

  ////////////////////
  // input sync + edge
  ////////////////////
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sync1_q <= '0;
      sync2_q <= '0;
      prev_q  <= '0;
      evt_q   <= '0;
    end else begin
      sync1_q <= gpio_in_i;
      sync2_q <= sync1_q;
      prev_q  <= sync2_q;
      evt_q   <= sync2_q & ~prev_q & irqen_q;  // rise on enabled lines
    end
  end

  assign gpio_out_o = out_q;
  assign gpio_dir_o = dir_q;
  assign gpio_evt_o = evt_q;  // 3 edges after the pin rises

  // read back, zero wait states
  always_comb begin
    rsp_o        = '0;
    rsp_o.pready = 1'b1;
    if (op == OP_READ) begin
      case (offs)
        `GPIO_DIR:   rsp_o.prdata = `APB_DATA_WIDTH'(dir_q);
        `GPIO_OUT:   rsp_o.prdata = `APB_DATA_WIDTH'(out_q);
        `GPIO_IN:    rsp_o.prdata = `APB_DATA_WIDTH'(sync2_q);
        `GPIO_IRQEN: rsp_o.prdata = `APB_DATA_WIDTH'(irqen_q);
        default:     rsp_o.prdata = '0;
      endcase
    end
  end

endmodule

/* apb_timer.sv */
/*
 * apb compare timer
 * ctrl/cmp/cnt registers, counter with restart on match
 */
`timescale 1ns/1ps
`include "soc_periph_defines.svh"

module apb_timer (
  input  logic                     clk_i,
  input  logic                     arst_n_i,
  input  soc_periph_pkg::apb_req_t req_i,
  output soc_periph_pkg::apb_rsp_t rsp_o,
  output logic                     tmr_evt_o
);
  import soc_periph_pkg::*;

  apb_op_e                    op;
  logic [7:0]                 offs;
  logic                       en_q;   // CTRL bit 0
  logic [`APB_DATA_WIDTH-1:0] cmp_q;
  logic [`APB_DATA_WIDTH-1:0] cnt_q;
  logic                       match;

  assign op    = apb_op(req_i);
  assign offs  = req_i.paddr[7:0];
  assign match = en_q & (cnt_q == cmp_q);

  // pulse in the matching cycle, period cmp+1
  assign tmr_evt_o = match;

  ////////////////////
  // counter and regs
  ////////////////////
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      en_q  <= 1'b0;
      cmp_q <= '0;
      cnt_q <= '0;
    end else begin
      if (op == OP_WRITE && offs == `TMR_CTRL) begin
        en_q  <= req_i.pwdata[0];
        cnt_q <= '0;  // ctrl write restarts the period
      end else if (en_q) begin
        cnt_q <= match ? '0 : cnt_q + 1'b1;
      end
      if (op == OP_WRITE && offs == `TMR_CMP) begin
        cmp_q <= req_i.pwdata;
      end
    end
  end

  // readback
  always_comb begin
    rsp_o        = '0;
    rsp_o.pready = 1'b1;
    if (op == OP_READ) begin
      case (offs)
        `TMR_CTRL: rsp_o.prdata = `APB_DATA_WIDTH'(en_q);
        `TMR_CMP:  rsp_o.prdata = cmp_q;
        `TMR_CNT:  rsp_o.prdata = cnt_q;
        default:   rsp_o.prdata = '0;
      endcase
    end
  end

endmodule

/* files.f */
+incdir+.
soc_periph_pkg.sv
periph_bus_decode.sv
apb_gpio.sv
apb_timer.sv
soc_event_gen.sv
soc_periph_top.sv
soc_periph_sva.sv
soc_periph_tb.sv

/* periph_bus_decode.sv */
/*
 * apb peripheral decoder
 * slot select on paddr[11:8], psel gating, response mux
 */
`timescale 1ns/1ps
`include "soc_periph_defines.svh"

module periph_bus_decode (
  input  soc_periph_pkg::apb_req_t apb_req_i,
  output soc_periph_pkg::apb_rsp_t apb_rsp_o,
  output soc_periph_pkg::apb_req_t gpio_req_o,
  output soc_periph_pkg::apb_req_t tmr_req_o,
  output soc_periph_pkg::apb_req_t evg_req_o,
  input  soc_periph_pkg::apb_rsp_t gpio_rsp_i,
  input  soc_periph_pkg::apb_rsp_t tmr_rsp_i,
  input  soc_periph_pkg::apb_rsp_t evg_rsp_i
);
  import soc_periph_pkg::*;

  periph_slot_e slot;

  ////////////////////
  // slot decode
  ////////////////////
  always_comb begin
    case (apb_req_i.paddr[11:8])
      `SLOT_GPIO:  slot = SLOT_GPIO;
      `SLOT_TIMER: slot = SLOT_TIMER;
      `SLOT_EVGEN: slot = SLOT_EVGEN;
      default:     slot = SLOT_NONE;
    endcase
  end

  // same request to every peer, only psel is steered
  always_comb begin
    gpio_req_o      = apb_req_i;
    tmr_req_o       = apb_req_i;
    evg_req_o       = apb_req_i;
    gpio_req_o.psel = apb_req_i.psel & (slot == SLOT_GPIO);
    tmr_req_o.psel  = apb_req_i.psel & (slot == SLOT_TIMER);
    evg_req_o.psel  = apb_req_i.psel & (slot == SLOT_EVGEN);
  end

  ////////////////////
  // response mux
  ////////////////////
  always_comb begin
    case (slot)
      SLOT_GPIO:  apb_rsp_o = gpio_rsp_i;
      SLOT_TIMER: apb_rsp_o = tmr_rsp_i;
      SLOT_EVGEN: apb_rsp_o = evg_rsp_i;
      default: begin
        apb_rsp_o         = '0;  // prdata stays 0
        apb_rsp_o.pready  = 1'b1;
        apb_rsp_o.pslverr = 1'b1;
      end
    endcase
  end

endmodule

/* run.sh */
#!/usr/bin/env bash
# build and run the soc peripheral testbench with verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal \
  -f files.f --top-module soc_periph_tb -o soc_periph_sim

# the simulator exit code is not trusted, the log decides
./obj_dir/soc_periph_sim | tee sim.log

if grep -qx "=== PASS ===" sim.log; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed, see sim.log"
  exit 1
fi

/* soc_event_gen.sv */
/*
 * soc event generator
 * pending bits, round-robin arbiter, event id fifo
 * mask/status registers and fc event valid/ready port
 */
`timescale 1ns/1ps
`include "soc_periph_defines.svh"

module soc_event_gen (
  input  logic                     clk_i,
  input  logic                     arst_n_i,
  input  soc_periph_pkg::apb_req_t req_i,
  output soc_periph_pkg::apb_rsp_t rsp_o,
  input  logic [`N_GPIO-1:0]       gpio_evt_i,
  input  logic                     tmr_evt_i,
  output logic                     fc_event_valid_o,
  output logic [`EVNT_WIDTH-1:0]   fc_event_data_o,
  input  logic                     fc_event_ready_i
);
  import soc_periph_pkg::*;

  localparam int NSRC  = `N_EVT_SRC;
  localparam int DEPTH = `EVT_FIFO_DEPTH;
  localparam int PW    = $clog2(DEPTH);
  localparam int CW    = $clog2(DEPTH + 1);
  localparam int SW    = $clog2(NSRC);

  apb_op_e                op;
  logic [7:0]             offs;
  logic [NSRC-1:0]        src_evt;
  logic [NSRC-1:0]        mask_q;
  logic [NSRC-1:0]        pend_q;
  logic [NSRC-1:0]        gnt_oh;
  logic [SW-1:0]          last_q;   // last granted source
  logic [SW-1:0]          gnt_idx;
  logic                   gnt_vld;
  logic [`EVNT_WIDTH-1:0] fifo_mem [DEPTH];
  logic [PW-1:0]          wr_ptr_q;
  logic [PW-1:0]          rd_ptr_q;
  logic [CW-1:0]          cnt_q;
  logic                   full;
  logic                   push;
  logic                   pop;

  assign op   = apb_op(req_i);
  assign offs = req_i.paddr[7:0];

  // source order: gpio lines, then timer
  assign src_evt[`N_GPIO-1:0]   = gpio_evt_i;
  assign src_evt[`TIMER_EVT_ID] = tmr_evt_i;

  ////////////////////
  // rr arbiter
  ////////////////////
  always_comb begin
    int idx;
    gnt_vld = 1'b0;
    gnt_idx = '0;
    for (int i = 1; i <= NSRC; i++) begin
      idx = int'(last_q) + i;  // search starts after last grant
      if (idx >= NSRC) idx = idx - NSRC;
      if (!gnt_vld && pend_q[idx]) begin
        gnt_vld = 1'b1;
        gnt_idx = SW'(idx);
      end
    end
  end

  assign full   = (cnt_q == CW'(DEPTH));
  assign push   = gnt_vld & ~full;  // full fifo leaves events pending
  assign pop    = fc_event_valid_o & fc_event_ready_i;
  assign gnt_oh = push ? (NSRC'(1) << gnt_idx) : '0;

  // pending set/clear, mask register
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pend_q <= '0;
      mask_q <= '1;                 // all sources enabled
      last_q <= SW'(NSRC - 1);      // first search begins at source 0
    end else begin
      // new pulse in the grant cycle re-arms the bit
      pend_q <= (pend_q & ~gnt_oh) | (src_evt & mask_q);
      if (push) last_q <= gnt_idx;
      if (op == OP_WRITE && offs == `EVG_MASK) mask_q <= req_i.pwdata[NSRC-1:0];
    end
  end

  ////////////////////
  // event fifo
  ////////////////////
  always_ff @(posedge clk_i) begin
    if (push) fifo_mem[wr_ptr_q] <= `EVNT_WIDTH'(gnt_idx);  // id = source index
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push) wr_ptr_q <= wr_ptr_q + 1'b1;  // depth is a power of 2
      if (pop)  rd_ptr_q <= rd_ptr_q + 1'b1;
      cnt_q <= cnt_q + CW'(push) - CW'(pop);
    end
  end

  // head stays put until ready
  assign fc_event_valid_o = (cnt_q != '0);
  assign fc_event_data_o  = fifo_mem[rd_ptr_q];

  // mask and status readback
  always_comb begin
    rsp_o        = '0;
    rsp_o.pready = 1'b1;
    if (op == OP_READ) begin
      case (offs)
        `EVG_MASK: rsp_o.prdata = `APB_DATA_WIDTH'(mask_q);
        `EVG_STATUS: begin
          rsp_o.prdata[CW-1:0]    = cnt_q;   // fifo fill
          rsp_o.prdata[8 +: NSRC] = pend_q;  // waiting sources
        end
        default: rsp_o.prdata = '0;
      endcase
    end
  end

endmodule

/* soc_periph_defines.svh */
/*
 * widths, peripheral address map and register offsets
 * event source ids, event fifo depth and fc event vector bits
 */
`ifndef SOC_PERIPH_DEFINES_SVH
`define SOC_PERIPH_DEFINES_SVH

// bus widths
`define APB_ADDR_WIDTH 32
`define APB_DATA_WIDTH 32

`define N_GPIO         8
`define EVNT_WIDTH     8
`define EVT_FIFO_DEPTH 4
`define N_EVT_SRC      9  // gpio 0..7, then timer
`define TIMER_EVT_ID   8

// paddr[11:8] slot codes
`define SLOT_GPIO  4'h0
`define SLOT_TIMER 4'h1
`define SLOT_EVGEN 4'h2

// register offsets, paddr[7:0]
`define GPIO_DIR   8'h00
`define GPIO_OUT   8'h04
`define GPIO_IN    8'h08
`define GPIO_IRQEN 8'h0C
`define TMR_CTRL   8'h00
`define TMR_CMP    8'h04
`define TMR_CNT    8'h08
`define EVG_MASK   8'h00
`define EVG_STATUS 8'h04

`define FC_EVT_TIMER 7   // timer irq line
`define FC_EVT_FIFO  11  // event fifo not empty

`endif

/* soc_periph_pkg.sv */
/*
 * apb request and response structs
 * slot and operation enums, access classifier
 */
`include "soc_periph_defines.svh"

package soc_periph_pkg;

  // master to slave
  typedef struct packed {
    logic [`APB_ADDR_WIDTH-1:0] paddr;
    logic [`APB_DATA_WIDTH-1:0] pwdata;
    logic                       pwrite;
    logic                       psel;
    logic                       penable;
  } apb_req_t;

  // slave to master
  typedef struct packed {
    logic [`APB_DATA_WIDTH-1:0] prdata;
    logic                       pready;
    logic                       pslverr;
  } apb_rsp_t;

  typedef enum logic [1:0] {
    SLOT_GPIO,
    SLOT_TIMER,
    SLOT_EVGEN,
    SLOT_NONE   // unmapped, answers with pslverr
  } periph_slot_e;

  typedef enum logic [1:0] {
    OP_IDLE,
    OP_READ,
    OP_WRITE
  } apb_op_e;

  // access phase only, setup cycle counts as idle
  function automatic apb_op_e apb_op(apb_req_t req);
    if (!(req.psel && req.penable)) return OP_IDLE;
    return req.pwrite ? OP_WRITE : OP_READ;
  endfunction

endpackage

/* soc_periph_sva.sv */
/*
 * protocol assertions for the soc event generator
 * fc event port hold and reset value
 * bound into every soc_event_gen instance
 */
`timescale 1ns/1ps
`include "soc_periph_defines.svh"

module soc_periph_sva (
  input logic                   clk_i,
  input logic                   arst_n_i,
  input logic                   fc_valid_i,
  input logic [`EVNT_WIDTH-1:0] fc_data_i,
  input logic                   fc_ready_i
);

  // stalled event keeps valid and its id
  hold_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    fc_valid_i && !fc_ready_i |=> fc_valid_i && $stable(fc_data_i))
    else $error("fc event dropped or changed while ready was low");

  rst_a: assert property (@(posedge clk_i) !arst_n_i |-> !fc_valid_i)
    else $error("fc event valid high during reset");

endmodule

bind soc_event_gen soc_periph_sva sva_inst (
  .clk_i      (clk_i),
  .arst_n_i   (arst_n_i),
  .fc_valid_i (fc_event_valid_o),
  .fc_data_i  (fc_event_data_o),
  .fc_ready_i (fc_event_ready_i)
);

/* soc_periph_tb.sv */
/*
 * testbench for the soc peripheral slice
 * clock, reset, apb tasks, lfsr, reference model
 * fc event checker and watchdog
 */
`timescale 1ns/1ps
`include "soc_periph_defines.svh"

module soc_periph_tb;
  import soc_periph_pkg::*;

  localparam int CLK_PERIOD = 8;
  localparam int RST_CYCLES = 8;
  localparam int READ_DLY   = 2;    // apb and pin sampling, after the falling edge
  localparam int MON_DLY    = 3;    // event checker sampling
  localparam int ROUNDS     = 4;
  localparam int XFER_CYC   = 3;    // setup, access, idle
  localparam int MAX_CMP    = 39;
  localparam int DRAIN_CYC  = 200;
  localparam int TEST_CYC   = RST_CYCLES
    + ROUNDS * (8 * XFER_CYC + 4) + 8 * XFER_CYC    // reset values, gpio regs
    + 8 * XFER_CYC                                  // unmapped slot
    + 3 * (MAX_CMP + 1) + 6 * XFER_CYC + DRAIN_CYC  // timer period
    + ROUNDS * (8 + 3 * XFER_CYC + DRAIN_CYC)       // random gpio edges
    + 40 + 6 * XFER_CYC + DRAIN_CYC;                // back-pressure
  localparam int WDOG_CYC   = 2 * TEST_CYC;
  localparam logic [31:0] FC_USED = (32'h1 << `FC_EVT_TIMER) | (32'h1 << `FC_EVT_FIFO);

  logic                   clk;
  logic                   arst_n;
  apb_req_t               apb_req;
  apb_rsp_t               apb_rsp;
  logic [`N_GPIO-1:0]     apbio_in;
  logic [`N_GPIO-1:0]     apbio_out;
  logic [`N_GPIO-1:0]     apbio_oe;
  logic [31:0]            fc_events;
  logic                   fc_event_valid;
  logic [`EVNT_WIDTH-1:0] fc_event_data;
  logic                   fc_event_ready;

  // register model
  logic [`N_GPIO-1:0]    m_dir   = '0;
  logic [`N_GPIO-1:0]    m_out   = '0;
  logic [`N_GPIO-1:0]    m_in    = '0;
  logic [`N_GPIO-1:0]    m_irqen = '0;
  logic [`N_EVT_SRC-1:0] m_mask  = '1;  // all sources on after reset
  logic                  m_ctrl  = 1'b0;
  logic [31:0]           m_cmp   = '0;

  int          exp_cnt [`N_EVT_SRC];   // expected id multiset
  int          exp_left = 0;
  logic [31:0] lfsr_state = 32'h83ea;

  soc_periph_top soc_periph_top_inst (
    .clk_i            (clk),
    .arst_n_i         (arst_n),
    .apb_req_i        (apb_req),
    .apb_rsp_o        (apb_rsp),
    .apbio_in_i       (apbio_in),
    .apbio_out_o      (apbio_out),
    .apbio_oe_o       (apbio_oe),
    .fc_events_o      (fc_events),
    .fc_event_valid_o (fc_event_valid),
    .fc_event_data_o  (fc_event_data),
    .fc_event_ready_i (fc_event_ready)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  ////////////////////
  // helpers
  ////////////////////
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("=== FAIL ===");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_eq(input string test, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      abort_run($sformatf("ERR %s exp=0x%08h act=0x%08h", test, exp, act));
    end
  endtask

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);  // one step per bit
      r = {r[30:0], lfsr_state[0]};
    end
    return r;
  endfunction

  function automatic logic [31:0] reg_addr(input logic [3:0] slot, input logic [7:0] offs);
    return {20'h0, slot, offs};
  endfunction

  ////////////////////
  // reference model
  ////////////////////
  function automatic logic [31:0] exp_reg(input logic [31:0] addr);
    logic [31:0] v;
    v = '0;  // unmapped slots and holes read 0
    if (addr[11:8] == `SLOT_GPIO) begin
      case (addr[7:0])
        `GPIO_DIR:   v = 32'(m_dir);
        `GPIO_OUT:   v = 32'(m_out);
        `GPIO_IN:    v = 32'(m_in);
        `GPIO_IRQEN: v = 32'(m_irqen);
        default:     v = '0;
      endcase
    end else if (addr[11:8] == `SLOT_TIMER) begin
      case (addr[7:0])
        `TMR_CTRL: v = 32'(m_ctrl);
        `TMR_CMP:  v = m_cmp;
        default:   v = '0;  // cnt, only read while stopped
      endcase
    end else if (addr[11:8] == `SLOT_EVGEN && addr[7:0] == `EVG_MASK) begin
      v = 32'(m_mask);
    end
    return v;
  endfunction

  function automatic void model_write(input logic [31:0] addr, input logic [31:0] data);
    if (addr[11:8] == `SLOT_GPIO) begin
      if (addr[7:0] == `GPIO_DIR)   m_dir   = data[`N_GPIO-1:0];
      if (addr[7:0] == `GPIO_OUT)   m_out   = data[`N_GPIO-1:0];
      if (addr[7:0] == `GPIO_IRQEN) m_irqen = data[`N_GPIO-1:0];
    end else if (addr[11:8] == `SLOT_TIMER) begin
      if (addr[7:0] == `TMR_CTRL) m_ctrl = data[0];
      if (addr[7:0] == `TMR_CMP)  m_cmp  = data;
    end else if (addr[11:8] == `SLOT_EVGEN && addr[7:0] == `EVG_MASK) begin
      m_mask = data[`N_EVT_SRC-1:0];
    end
  endfunction

  // ids that should reach the fc port, gpio lines then timer
  function automatic logic [`N_EVT_SRC-1:0] exp_events(input logic [`N_GPIO-1:0] rise,
      input logic [`N_GPIO-1:0] irqen, input logic [`N_EVT_SRC-1:0] mask, input logic tmr);
    logic [`N_EVT_SRC-1:0] s;
    s[`N_GPIO-1:0]   = rise & irqen & mask[`N_GPIO-1:0];
    s[`TIMER_EVT_ID] = tmr & mask[`TIMER_EVT_ID];
    return s;
  endfunction

  function automatic void add_expected(input logic [`N_EVT_SRC-1:0] set);
    for (int i = 0; i < `N_EVT_SRC; i++) begin
      if (set[i]) begin
        exp_cnt[i]++;
        exp_left++;
      end
    end
  endfunction

  ////////////////////
  // apb tasks
  ////////////////////
  task automatic apb_xfer(input logic wr, input logic [31:0] addr, input logic [31:0] wdata,
      output logic [31:0] rdata, output logic err);
    @(negedge clk);  // setup
    apb_req.paddr   = addr;
    apb_req.pwdata  = wdata;
    apb_req.pwrite  = wr;
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    @(negedge clk);  // access, zero wait states
    apb_req.penable = 1'b1;
    #READ_DLY;
    rdata = apb_rsp.prdata;
    err   = apb_rsp.pslverr;
    check_eq("apb_pready", 32'h1, 32'(apb_rsp.pready));
    @(negedge clk);
    apb_req.psel    = 1'b0;
    apb_req.penable = 1'b0;
  endtask

  task automatic write_reg(input string test, input logic [31:0] addr, input logic [31:0] data);
    logic [31:0] rd;
    logic        err;
    apb_xfer(1'b1, addr, data, rd, err);
    check_eq({test, "_wr_err"}, 32'(addr[11:8] > 4'h2), 32'(err));
    if (addr[11:8] <= 4'h2) model_write(addr, data);
  endtask

  task automatic read_check(input string test, input logic [31:0] addr);
    logic [31:0] rd;
    logic        err;
    apb_xfer(1'b0, addr, 32'h0, rd, err);
    check_eq({test, "_rd_err"}, 32'(addr[11:8] > 4'h2), 32'(err));
    check_eq($sformatf("%s_rd_%03h", test, addr[11:0]), exp_reg(addr), rd);
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) @(negedge clk);
  endtask

  task automatic wait_timer_pulse(input int max_cyc, output int cycles);
    cycles = 0;
    do begin
      @(negedge clk);
      #READ_DLY;
      cycles++;
      if (cycles > max_cyc) abort_run("timer pulse never showed on fc_events_o bit 7");
    end while (!fc_events[`FC_EVT_TIMER]);
  endtask

  // wait until every expected id is taken, ready random or high
  task automatic wait_drained(input logic rnd_ready, input int max_cyc);
    int n;
    n = 0;
    while (exp_left != 0 || fc_event_valid) begin
      @(negedge clk);
      fc_event_ready = rnd_ready ? 1'(rand_bits(1)) : 1'b1;
      #READ_DLY;
      n++;
      if (n > max_cyc) abort_run($sformatf("timeout with %0d events still missing", exp_left));
    end
  endtask

  ////////////////////
  // event checker
  ////////////////////
  always begin : ev_check
    int id;
    @(negedge clk);
    #MON_DLY;  // all inputs and outputs settled
    if (arst_n) begin
      check_eq("fc_vec_fifo", 32'(fc_event_valid), 32'(fc_events[`FC_EVT_FIFO]));
      check_eq("fc_vec_unused", 32'h0, fc_events & ~FC_USED);
      if (fc_event_valid && fc_event_ready) begin
        id = int'(fc_event_data);
        assert (id < `N_EVT_SRC && exp_cnt[id] > 0) else begin
          abort_run($sformatf("event id %0d arrived but was not expected", id));
        end
        exp_cnt[id]--;
        exp_left--;
      end
    end
  end

  initial begin : watchdog
    #(WDOG_CYC * CLK_PERIOD);
    abort_run("watchdog expired before the tests finished");
  end

  ////////////////////
  // test sequence
  ////////////////////
  initial begin : main_seq
    logic [31:0]           rd;
    logic                  err;
    logic [`N_GPIO-1:0]    r;
    logic [`N_GPIO-1:0]    ie;
    logic [`N_EVT_SRC-1:0] mk;
    int                    n_cmp;
    int                    gap;
    arst_n         = 1'b0;
    apb_req        = '0;
    apbio_in       = '0;
    fc_event_ready = 1'b1;
    for (int i = 0; i < `N_EVT_SRC; i++) exp_cnt[i] = 0;
    repeat (RST_CYCLES) @(negedge clk);
    arst_n = 1'b1;
    #READ_DLY;
    check_eq("rst_valid", 32'h0, 32'(fc_event_valid));
    check_eq("rst_oe", 32'h0, 32'(apbio_oe));
    check_eq("rst_events", 32'h0, fc_events);
    read_check("rst", reg_addr(`SLOT_GPIO, `GPIO_DIR));
    read_check("rst", reg_addr(`SLOT_GPIO, `GPIO_OUT));
    read_check("rst", reg_addr(`SLOT_GPIO, `GPIO_IRQEN));
    read_check("rst", reg_addr(`SLOT_TIMER, `TMR_CTRL));
    read_check("rst", reg_addr(`SLOT_TIMER, `TMR_CMP));
    read_check("rst", reg_addr(`SLOT_TIMER, `TMR_CNT));
    read_check("rst", reg_addr(`SLOT_EVGEN, `EVG_MASK));

    // 1: gpio registers and pins
    for (int k = 0; k < ROUNDS; k++) begin
      write_reg("t1", reg_addr(`SLOT_GPIO, `GPIO_DIR), rand_bits(`N_GPIO));
      write_reg("t1", reg_addr(`SLOT_GPIO, `GPIO_OUT), rand_bits(`N_GPIO));
      @(negedge clk);
      apbio_in = `N_GPIO'(rand_bits(`N_GPIO));  // irqen is 0, no events
      m_in     = apbio_in;
      idle_cycles(2);                 // through the synchronizer
      read_check("t1", reg_addr(`SLOT_GPIO, `GPIO_DIR));
      read_check("t1", reg_addr(`SLOT_GPIO, `GPIO_OUT));
      read_check("t1", reg_addr(`SLOT_GPIO, `GPIO_IN));
      #READ_DLY;
      check_eq("t1_out_pins", 32'(m_out), 32'(apbio_out));
      check_eq("t1_oe_pins", 32'(m_dir), 32'(apbio_oe));
    end

    // 2: unmapped slot, offsets that would hit gpio out and evgen mask
    write_reg("t2", reg_addr(4'h3, `GPIO_OUT), rand_bits(32));
    write_reg("t2", reg_addr(4'hF, `EVG_MASK), 32'h0);
    read_check("t2", reg_addr(4'h3, `GPIO_OUT));
    read_check("t2", reg_addr(`SLOT_GPIO, `GPIO_OUT));
    read_check("t2", reg_addr(`SLOT_GPIO, `GPIO_DIR));
    read_check("t2", reg_addr(`SLOT_EVGEN, `EVG_MASK));

    // 3: timer period, only the timer unmasked
    n_cmp = 8 + int'(rand_bits(5));
    write_reg("t3", reg_addr(`SLOT_EVGEN, `EVG_MASK), 32'h1 << `TIMER_EVT_ID);
    write_reg("t3", reg_addr(`SLOT_TIMER, `TMR_CMP), 32'(n_cmp));
    write_reg("t3", reg_addr(`SLOT_TIMER, `TMR_CTRL), 32'h1);
    wait_timer_pulse(MAX_CMP + 2, gap);  // first one counts from the enable
    add_expected(exp_events('0, '0, m_mask, 1'b1));
    for (int k = 0; k < 2; k++) begin
      wait_timer_pulse(MAX_CMP + 2, gap);
      check_eq("t3_period", 32'(n_cmp + 1), 32'(gap));
      add_expected(exp_events('0, '0, m_mask, 1'b1));
    end
    write_reg("t3", reg_addr(`SLOT_TIMER, `TMR_CTRL), 32'h0);
    read_check("t3", reg_addr(`SLOT_TIMER, `TMR_CMP));
    read_check("t3", reg_addr(`SLOT_TIMER, `TMR_CNT));
    wait_drained(1'b0, DRAIN_CYC);

    // 4: random edges, irqen and mask, random ready
    for (int k = 0; k < ROUNDS; k++) begin
      @(negedge clk);
      apbio_in = '0;  // falling edges raise nothing
      m_in     = '0;
      idle_cycles(4);
      ie = `N_GPIO'(rand_bits(`N_GPIO));
      mk = `N_EVT_SRC'(rand_bits(`N_EVT_SRC));
      r  = `N_GPIO'(rand_bits(`N_GPIO));
      write_reg("t4", reg_addr(`SLOT_GPIO, `GPIO_IRQEN), 32'(ie));
      write_reg("t4", reg_addr(`SLOT_EVGEN, `EVG_MASK), 32'(mk));
      add_expected(exp_events(r, m_irqen, m_mask, 1'b0));
      @(negedge clk);
      apbio_in = r;
      m_in     = r;
      wait_drained(1'b1, DRAIN_CYC);
    end

    // 5: ready low, all 9 sources fire
    @(negedge clk);
    fc_event_ready = 1'b0;
    apbio_in       = '0;
    m_in           = '0;
    idle_cycles(4);
    write_reg("t5", reg_addr(`SLOT_GPIO, `GPIO_IRQEN), 32'hFF);
    write_reg("t5", reg_addr(`SLOT_EVGEN, `EVG_MASK), 32'h1FF);
    add_expected(exp_events('1, m_irqen, m_mask, 1'b1));
    @(negedge clk);
    apbio_in = '1;
    m_in     = '1;
    idle_cycles(12);  // fifo full, rest pending
    write_reg("t5", reg_addr(`SLOT_TIMER, `TMR_CMP), 32'h3);
    write_reg("t5", reg_addr(`SLOT_TIMER, `TMR_CTRL), 32'h1);
    wait_timer_pulse(8, gap);
    write_reg("t5", reg_addr(`SLOT_TIMER, `TMR_CTRL), 32'h0);
    idle_cycles(4);
    apb_xfer(1'b0, reg_addr(`SLOT_EVGEN, `EVG_STATUS), 32'h0, rd, err);
    check_eq("t5_status_err", 32'h0, 32'(err));
    check_eq("t5_fifo_count", `EVT_FIFO_DEPTH, 32'(rd[2:0]));
    check_eq("t5_pending_n", `N_EVT_SRC - `EVT_FIFO_DEPTH, $countones(rd[8 +: `N_EVT_SRC]));
    check_eq("t5_timer_pending", 32'h1, 32'(rd[8 + `TIMER_EVT_ID]));
    #READ_DLY;
    check_eq("t5_valid_stalled", 32'h1, 32'(fc_event_valid));
    wait_drained(1'b0, DRAIN_CYC);  // ready back high
    idle_cycles(10);

    if (exp_left == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

/* soc_periph_top.sv */
/*
 * peripheral slice top
 * decoder, gpio, timer, event generator, fc event vector
 */
`timescale 1ns/1ps
`include "soc_periph_defines.svh"

module soc_periph_top (
  input  logic                     clk_i,
  input  logic                     arst_n_i,
  input  soc_periph_pkg::apb_req_t apb_req_i,
  output soc_periph_pkg::apb_rsp_t apb_rsp_o,
  input  logic [`N_GPIO-1:0]       apbio_in_i,
  output logic [`N_GPIO-1:0]       apbio_out_o,
  output logic [`N_GPIO-1:0]       apbio_oe_o,
  output logic [31:0]              fc_events_o,
  output logic                     fc_event_valid_o,
  output logic [`EVNT_WIDTH-1:0]   fc_event_data_o,
  input  logic                     fc_event_ready_i
);
  import soc_periph_pkg::*;

  apb_req_t           gpio_req, tmr_req, evg_req;
  apb_rsp_t           gpio_rsp, tmr_rsp, evg_rsp;
  logic [`N_GPIO-1:0] gpio_evt;
  logic               tmr_evt;

  ////////////////////
  // bus
  ////////////////////
  periph_bus_decode i_periph_bus_decode (
    .apb_req_i  (apb_req_i),
    .apb_rsp_o  (apb_rsp_o),
    .gpio_req_o (gpio_req),
    .tmr_req_o  (tmr_req),
    .evg_req_o  (evg_req),
    .gpio_rsp_i (gpio_rsp),
    .tmr_rsp_i  (tmr_rsp),
    .evg_rsp_i  (evg_rsp)
  );

  ////////////////////
  // peers
  ////////////////////
  apb_gpio i_apb_gpio (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .req_i      (gpio_req),
    .rsp_o      (gpio_rsp),
    .gpio_in_i  (apbio_in_i),
    .gpio_out_o (apbio_out_o),
    .gpio_dir_o (apbio_oe_o),   // dir doubles as pad oe
    .gpio_evt_o (gpio_evt)
  );

  apb_timer i_apb_timer (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .req_i     (tmr_req),
    .rsp_o     (tmr_rsp),
    .tmr_evt_o (tmr_evt)
  );

  soc_event_gen i_soc_event_gen (
    .clk_i            (clk_i),
    .arst_n_i         (arst_n_i),
    .req_i            (evg_req),
    .rsp_o            (evg_rsp),
    .gpio_evt_i       (gpio_evt),
    .tmr_evt_i        (tmr_evt),
    .fc_event_valid_o (fc_event_valid_o),
    .fc_event_data_o  (fc_event_data_o),
    .fc_event_ready_i (fc_event_ready_i)
  );

  // fc event vector, unused lines tied low
  always_comb begin
    fc_events_o                = '0;
    fc_events_o[`FC_EVT_TIMER] = tmr_evt;           // timer irq
    fc_events_o[`FC_EVT_FIFO]  = fc_event_valid_o;  // fifo not empty
  end

endmodule
